// File: source/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// datapath widths
`define XLEN       32
`define REG_ADDR_W 5
`define MASK_W     4            // one bit per byte of a word

`define RESET_PC   32'h8000_0000

// major opcodes, inst[6:0]
`define OP_IMM     7'b0010011
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_SYSTEM  7'b1110011

// load/store size codes in funct3
`define F3_B       3'b000
`define F3_H       3'b001
`define F3_W       3'b010
`define F3_BU      3'b100
`define F3_HU      3'b101

`endif

// File: source/rv_core_pkg.sv
`include "rv_core_settings.svh"

package rv_core_pkg;

  // one data or address word
  typedef logic [`XLEN-1:0] word_t;

  // what feeds the A side of the shared adder
  typedef enum logic [1:0] {
    SRC_A_ZERO, // lui
    SRC_A_PC,   // auipc, jal
    SRC_A_RS1   // addi, jalr, loads, stores
  } src_a_e;

  // write-back source
  typedef enum logic [1:0] {
    WB_ADD,  // adder result
    WB_SNPC, // link address pc+4
    WB_LOAD  // extracted load data
  } wb_sel_e;

  // decoded control for one instruction
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [2:0]             funct3;
    src_a_e                 src_a;
    word_t                  imm;       // already sign extended / shifted
    logic                   reg_wen;
    logic                   mem_read;
    logic                   mem_write;
    logic                   jump;      // jal or jalr
    logic                   is_ebreak;
    wb_sel_e                wb_sel;
  } ctrl_t;

  // data memory request, answered combinationally
  typedef struct packed {
    word_t             addr;
    word_t             wdata;  // lane aligned to wmask
    logic [`MASK_W-1:0] wmask;
    logic              read;
    logic              write;
  } dmem_req_t;

endpackage

// File: source/inst_decode.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module inst_decode (
  input  rv_core_pkg::word_t inst,
  output rv_core_pkg::ctrl_t ctrl
);

  logic [6:0]         opcode;
  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_s;
  rv_core_pkg::word_t imm_u;
  rv_core_pkg::word_t imm_j;

  assign opcode = inst[6:0];

  // immediate formats, all sign extended from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000}; // upper 20 bits, low bits zero
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // register fields sit at fixed positions for every format
    ctrl.rd        = inst[11:7];
    ctrl.rs1       = inst[19:15];
    ctrl.rs2       = inst[24:20];
    ctrl.funct3    = inst[14:12];

    // defaults: no side effects, pc+4
    ctrl.src_a     = rv_core_pkg::SRC_A_ZERO;
    ctrl.imm       = '0;
    ctrl.reg_wen   = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.jump      = 1'b0;
    ctrl.is_ebreak = 1'b0;
    ctrl.wb_sel    = rv_core_pkg::WB_ADD;

    case (opcode)
      `OP_IMM: begin
        ctrl.src_a   = rv_core_pkg::SRC_A_RS1;
        ctrl.imm     = imm_i;
        ctrl.reg_wen = (inst[14:12] == 3'b000); // addi only
      end
      `OP_LUI: begin
        ctrl.imm     = imm_u; // 0 + imm
        ctrl.reg_wen = 1'b1;
      end
      `OP_AUIPC: begin
        ctrl.src_a   = rv_core_pkg::SRC_A_PC;
        ctrl.imm     = imm_u;
        ctrl.reg_wen = 1'b1;
      end
      `OP_JAL: begin
        ctrl.src_a   = rv_core_pkg::SRC_A_PC;
        ctrl.imm     = imm_j;
        ctrl.reg_wen = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.wb_sel  = rv_core_pkg::WB_SNPC; // link
      end
      `OP_JALR: begin
        ctrl.src_a   = rv_core_pkg::SRC_A_RS1;
        ctrl.imm     = imm_i;
        ctrl.reg_wen = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.wb_sel  = rv_core_pkg::WB_SNPC;
      end
      `OP_LOAD: begin
        ctrl.src_a    = rv_core_pkg::SRC_A_RS1;
        ctrl.imm      = imm_i;
        ctrl.reg_wen  = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.wb_sel   = rv_core_pkg::WB_LOAD;
      end
      `OP_STORE: begin
        ctrl.src_a     = rv_core_pkg::SRC_A_RS1;
        ctrl.imm       = imm_s;
        ctrl.mem_read  = 1'b1; // stores also raise read
        ctrl.mem_write = 1'b1;
      end
      `OP_SYSTEM: begin
        ctrl.is_ebreak = 1'b1;
      end
      default: begin
        // unsupported opcode retires as a nop
      end
    endcase
  end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   wen,
  input  logic [`REG_ADDR_W-1:0] waddr,
  input  logic [`REG_ADDR_W-1:0] raddr1,
  input  logic [`REG_ADDR_W-1:0] raddr2,
  input  rv_core_pkg::word_t     wdata,
  output rv_core_pkg::word_t     rdata1,
  output rv_core_pkg::word_t     rdata2
);

  localparam int NUM_REGS = 2 ** `REG_ADDR_W;

  rv_core_pkg::word_t regs [NUM_REGS];

  // write port, x0 never written
  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous reads
  always_comb begin
    if (raddr1 == '0) begin
      rdata1 = '0;
    end else begin
      rdata1 = regs[raddr1];
    end
  end

  always_comb begin
    if (raddr2 == '0) begin
      rdata2 = '0;
    end else begin
      rdata2 = regs[raddr2];
    end
  end

endmodule

// File: source/pc_unit.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module pc_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               jump,
  input  rv_core_pkg::word_t target,
  output rv_core_pkg::word_t pc,
  output rv_core_pkg::word_t snpc
);

  rv_core_pkg::word_t dnpc;

  // static next pc
  assign snpc = pc + 32'd4;

  // dynamic next pc
  always_comb begin
    if (jump) begin
      // bit 0 cleared for jalr, jal targets are even anyway
      dnpc = {target[`XLEN-1:1], 1'b0};
    end else begin
      dnpc = snpc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RESET_PC;
    end else begin
      pc <= dnpc; // one instruction per cycle
    end
  end

endmodule

// File: source/operand_adder.sv
`timescale 1ns/1ps

module operand_adder (
  input  rv_core_pkg::ctrl_t ctrl,
  input  rv_core_pkg::word_t pc,
  input  rv_core_pkg::word_t rs1_data,
  output rv_core_pkg::word_t add_out
);

  rv_core_pkg::word_t op_a;

  // A side of the adder
  always_comb begin
    case (ctrl.src_a)
      rv_core_pkg::SRC_A_PC: begin
        op_a = pc;       // auipc, jal
      end
      rv_core_pkg::SRC_A_RS1: begin
        op_a = rs1_data; // addi, jalr, load/store address
      end
      default: begin
        op_a = '0;       // lui passes the immediate
      end
    endcase
  end

  // single adder shared by results, jump targets and addresses
  assign add_out = op_a + ctrl.imm;

endmodule

// File: source/mem_request.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module mem_request (
  input  logic                   rst_n,
  input  rv_core_pkg::ctrl_t     ctrl,
  input  rv_core_pkg::word_t     add_out,
  input  rv_core_pkg::word_t     rs2_data,
  output rv_core_pkg::dmem_req_t dmem_req
);

  logic [1:0]         offset;
  logic [`MASK_W-1:0] mask;

  assign offset = add_out[1:0];

  // byte mask from size and address low bits
  always_comb begin
    case (ctrl.funct3)
      `F3_B: begin
        mask = 4'b0001 << offset;
      end
      `F3_H: begin
        if (offset[0]) begin
          mask = '0; // misaligned half
        end else begin
          mask = 4'b0011 << offset;
        end
      end
      `F3_W: begin
        mask = (offset == 2'b00) ? 4'b1111 : 4'b0000;
      end
      default: begin
        mask = '0;
      end
    endcase
  end

  always_comb begin
    dmem_req.addr  = add_out;
    dmem_req.wdata = rs2_data << {offset, 3'b000}; // move into byte lanes
    dmem_req.wmask = ctrl.mem_write ? mask : '0;
    // no memory traffic while in reset
    dmem_req.read  = rst_n & ctrl.mem_read;
    dmem_req.write = rst_n & ctrl.mem_write;
  end

endmodule

// File: source/load_result.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module load_result (
  input  rv_core_pkg::ctrl_t ctrl,
  input  rv_core_pkg::word_t add_out,
  input  rv_core_pkg::word_t snpc,
  input  rv_core_pkg::word_t dmem_rdata,
  output rv_core_pkg::word_t wb_data
);

  logic [1:0]         offset;
  rv_core_pkg::word_t shifted;
  logic [7:0]         ld_byte;
  logic [15:0]        ld_half;
  logic               half_ok;
  logic               word_ok;
  rv_core_pkg::word_t load_data;

  assign offset  = add_out[1:0];
  assign shifted = dmem_rdata >> {offset, 3'b000}; // addressed byte to lane 0
  assign ld_byte = shifted[7:0];
  assign ld_half = shifted[15:0];
  assign half_ok = ~offset[0];
  assign word_ok = (offset == 2'b00);

  // extract and extend
  always_comb begin
    case (ctrl.funct3)
      `F3_B: begin
        load_data = {{24{ld_byte[7]}}, ld_byte};
      end
      `F3_BU: begin
        load_data = {24'h00_0000, ld_byte};
      end
      `F3_H: begin
        load_data = half_ok ? {{16{ld_half[15]}}, ld_half} : '0;
      end
      `F3_HU: begin
        load_data = half_ok ? {16'h0000, ld_half} : '0;
      end
      `F3_W: begin
        load_data = word_ok ? dmem_rdata : '0;
      end
      default: begin
        load_data = '0; // illegal size
      end
    endcase
  end

  // write-back mux
  always_comb begin
    case (ctrl.wb_sel)
      rv_core_pkg::WB_SNPC: begin
        wb_data = snpc;
      end
      rv_core_pkg::WB_LOAD: begin
        wb_data = load_data;
      end
      default: begin
        wb_data = add_out;
      end
    endcase
  end

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_core_pkg::word_t     inst,
  output rv_core_pkg::word_t     pc,
  output rv_core_pkg::dmem_req_t dmem_req,
  input  rv_core_pkg::word_t     dmem_rdata,
  output logic                   ebreak
);

  rv_core_pkg::ctrl_t ctrl;
  rv_core_pkg::word_t rs1_data;
  rv_core_pkg::word_t rs2_data;
  rv_core_pkg::word_t add_out;
  rv_core_pkg::word_t snpc;
  rv_core_pkg::word_t wb_data;

  // decode
  inst_decode decode_i (
    .inst (inst),
    .ctrl (ctrl)
  );

  reg_file regs_i (
    .clk    (clk),
    .wen    (ctrl.reg_wen),
    .waddr  (ctrl.rd),
    .raddr1 (ctrl.rs1),
    .raddr2 (ctrl.rs2),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  // execute
  operand_adder adder_i (
    .ctrl     (ctrl),
    .pc       (pc),
    .rs1_data (rs1_data),
    .add_out  (add_out)
  );

  pc_unit pc_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .jump   (ctrl.jump),
    .target (add_out),
    .pc     (pc),
    .snpc   (snpc)
  );

  // result
  mem_request mem_req_i (
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .add_out  (add_out),
    .rs2_data (rs2_data),
    .dmem_req (dmem_req)
  );

  load_result load_i (
    .ctrl       (ctrl),
    .add_out    (add_out),
    .snpc       (snpc),
    .dmem_rdata (dmem_rdata),
    .wb_data    (wb_data)
  );

  assign ebreak = ctrl.is_ebreak;

endmodule

// File: verif/tb_memory.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module tb_memory (
  input  logic                   clk,
  input  rv_core_pkg::word_t     pc,
  output rv_core_pkg::word_t     inst,
  input  rv_core_pkg::dmem_req_t dmem_req,
  output rv_core_pkg::word_t     dmem_rdata,
  output int                     prog_len
);

  localparam int WORDS = 2048; // 8 KiB image at 0x8000_0000 with data from 0x8000_1000

  rv_core_pkg::word_t mem [WORDS];
  integer             seed;
  int                 n;
  int                 written[$]; // registers that hold a known value

  // RV32 encoders
  function automatic rv_core_pkg::word_t i_type(input int imm, input int rs1,
                                                input logic [2:0] f3, input int rd,
                                                input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic rv_core_pkg::word_t s_type(input int imm, input int rs2,
                                                input int rs1, input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `OP_STORE};
  endfunction

  function automatic rv_core_pkg::word_t u_type(input int imm, input int rd,
                                                input logic [6:0] op);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic rv_core_pkg::word_t j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OP_JAL};
  endfunction

  // x2..x31 only since x1 keeps the data base
  function automatic int pick_reg();
    return 2 + ({$random(seed)} % 30);
  endfunction

  function automatic int pick_written();
    return written[{$random(seed)} % written.size()];
  endfunction

  task automatic emit(input rv_core_pkg::word_t w);
    mem[n] = w;
    n++;
  endtask

  // save a register to the next result slot, 0x100 above the data base
  task automatic save_reg(input int r);
    emit(s_type(256 + 4 * (n % 64), r, 1, `F3_W));
  endtask

  task automatic load_series(input logic [2:0] f3, input int step);
    int rd;
    for (int off = 0; off < 4; off += step) begin
      rd = pick_reg();
      emit(i_type(4 * ({$random(seed)} % 64) + off, 1, f3, rd, `OP_LOAD));
      written.push_back(rd);
      save_reg(rd);
    end
  endtask

  // every byte offset, misaligned halves and words included
  task automatic store_series(input logic [2:0] f3);
    for (int off = 0; off < 4; off++) begin
      emit(s_type(512 + 4 * ({$random(seed)} % 64) + off, pick_written(), 1, f3));
    end
  endtask

  initial begin
    int rd;
    int rb;
    seed = 32'hd8ef980a;
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = $random(seed);
    end
    n = 0;
    emit(s_type(2044, 0, 0, `F3_W));     // sw of x0 to 0x7fc sits at the reset pc
    emit(u_type(32'h80001, 1, `OP_LUI)); // x1 = 0x8000_1000
    rd = pick_reg();
    emit(i_type($random(seed), 0, 3'b000, rd, `OP_IMM));
    written.push_back(rd);
    save_reg(rd);
    rd = pick_reg();
    emit(u_type($random(seed), rd, `OP_LUI));
    written.push_back(rd);
    save_reg(rd);
    rd = pick_reg();
    emit(u_type($random(seed), rd, `OP_AUIPC));
    written.push_back(rd);
    save_reg(rd);
    load_series(`F3_B, 1);
    load_series(`F3_BU, 1);
    load_series(`F3_H, 2);
    load_series(`F3_HU, 2);
    load_series(`F3_W, 4);
    store_series(`F3_B);
    store_series(`F3_H);
    store_series(`F3_W);
    rd = pick_reg();
    emit(j_type(8, rd));          // skips the next word
    emit(32'h0000_0033);          // r-type that is never reached
    save_reg(rd);
    rb = pick_reg();
    rd = pick_reg();
    emit(u_type(0, rb, `OP_AUIPC));
    emit(i_type(13, rb, 3'b000, rd, `OP_JALR)); // odd target with bit 0 dropped
    emit(32'h0000_0033);
    save_reg(rd);
    emit(32'h0010_0073);          // ebreak
    prog_len = n;
  end

  assign inst       = mem[pc[12:2]];
  assign dmem_rdata = mem[dmem_req.addr[12:2]];

  always @(posedge clk) begin
    if (dmem_req.write) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_req.wmask[b]) begin
          mem[dmem_req.addr[12:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_core_tb;

  logic                   clk;
  logic                   rst_n;
  rv_core_pkg::word_t     inst;
  rv_core_pkg::word_t     pc;
  rv_core_pkg::dmem_req_t dmem_req;
  rv_core_pkg::word_t     dmem_rdata;
  logic                   ebreak;
  int                     prog_len;

  // architectural shadow state
  rv_core_pkg::word_t regs [32];
  rv_core_pkg::word_t smem [2048];
  rv_core_pkg::word_t exp_pc;
  int                 reset_cycles;

  rv_core dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .pc         (pc),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .ebreak     (ebreak)
  );

  tb_memory mem_i (
    .clk        (clk),
    .pc         (pc),
    .inst       (inst),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .prog_len   (prog_len)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n        = 1'b0;
    exp_pc       = `RESET_PC;
    reset_cycles = 0;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < 2048; i++) begin
      smem[i] = mem_i.mem[i]; // image is untouched until now
    end
  end

  // watchdog sized from the program length
  initial begin
    #1;
    #((16 + 2 * prog_len + 20) * 4);
    $display("timeout: ebreak never reached");
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input rv_core_pkg::word_t exp,
                             input rv_core_pkg::word_t act);
    assert (act === exp) else begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  always @(posedge clk) begin : model
    logic [6:0]         opcode;
    logic [2:0]         f3;
    rv_core_pkg::word_t imm_i;
    rv_core_pkg::word_t imm_s;
    rv_core_pkg::word_t imm_u;
    rv_core_pkg::word_t imm_j;
    rv_core_pkg::word_t next;
    rv_core_pkg::word_t val;
    rv_core_pkg::word_t addr;
    rv_core_pkg::word_t lane;
    logic [3:0]         mask;
    logic               wen;
    logic               is_mem;

    if (!rst_n) begin
      if (reset_cycles > 0) begin // pc is unknown before the first edge
        check_value("pc", `RESET_PC, pc);
        check_value("dmem_req.read", 0, dmem_req.read);
        check_value("dmem_req.write", 0, dmem_req.write);
      end
      reset_cycles++;
    end else begin
      opcode = inst[6:0];
      f3     = inst[14:12];
      imm_i  = {{20{inst[31]}}, inst[31:20]};
      imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_u  = {inst[31:12], 12'h000};
      imm_j  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      next   = pc + 4;
      val    = '0;
      wen    = 1'b0;
      is_mem = 1'b0;
      check_value("pc", exp_pc, pc);
      check_value("ebreak", opcode == `OP_SYSTEM, ebreak);
      case (opcode)
        `OP_IMM: begin
          wen = (f3 == 3'b000);
          val = regs[inst[19:15]] + imm_i;
        end
        `OP_LUI: begin
          wen = 1'b1;
          val = imm_u;
        end
        `OP_AUIPC: begin
          wen = 1'b1;
          val = pc + imm_u;
        end
        `OP_JAL: begin
          wen  = 1'b1;
          val  = pc + 4;
          next = pc + imm_j;
        end
        `OP_JALR: begin
          wen  = 1'b1;
          val  = pc + 4;
          next = (regs[inst[19:15]] + imm_i) & ~32'h1;
        end
        `OP_LOAD: begin
          is_mem = 1'b1;
          wen    = 1'b1;
          addr   = regs[inst[19:15]] + imm_i;
          check_value("dmem_req.read", 1, dmem_req.read);
          check_value("dmem_req.write", 0, dmem_req.write);
          check_value("dmem_req.addr", addr, dmem_req.addr);
          lane = smem[addr[12:2]] >> (8 * addr[1:0]);
          case (f3)
            `F3_B:   val = {{24{lane[7]}}, lane[7:0]};
            `F3_BU:  val = {24'h0, lane[7:0]};
            `F3_H:   val = {{16{lane[15]}}, lane[15:0]};
            `F3_HU:  val = {16'h0, lane[15:0]};
            default: val = lane;
          endcase
        end
        `OP_STORE: begin
          is_mem = 1'b1;
          addr   = regs[inst[19:15]] + imm_s;
          // misaligned half or word writes no byte
          case (f3)
            `F3_B:   mask = 4'b0001 << addr[1:0];
            `F3_H:   mask = addr[0] ? 4'b0000 : 4'b0011 << addr[1:0];
            default: mask = (addr[1:0] == 2'b00) ? 4'b1111 : 4'b0000;
          endcase
          check_value("dmem_req.read", 1, dmem_req.read);
          check_value("dmem_req.write", 1, dmem_req.write);
          check_value("dmem_req.addr", addr, dmem_req.addr);
          check_value("dmem_req.wmask", mask, dmem_req.wmask);
          val = regs[inst[24:20]] << (8 * addr[1:0]);
          check_value("dmem_req.wdata", val, dmem_req.wdata);
          for (int b = 0; b < 4; b++) begin
            if (mask[b]) smem[addr[12:2]][8*b +: 8] = val[8*b +: 8];
          end
        end
        default: begin
        end
      endcase
      if (!is_mem) begin
        check_value("dmem_req.read", 0, dmem_req.read);
        check_value("dmem_req.write", 0, dmem_req.write);
      end
      if (wen && inst[11:7] != 5'd0) regs[inst[11:7]] = val;
      exp_pc = next;
      if (opcode == `OP_SYSTEM) begin
        $display("TEST PASS");
        $finish;
      end
    end
  end

endmodule

// File: files.f
+incdir+source
source/rv_core_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/pc_unit.sv
source/operand_adder.sv
source/mem_request.sv
source/load_result.sv
source/rv_core.sv
verif/tb_memory.sv
verif/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rv_core_pkg.sv
      - source/inst_decode.sv
      - source/reg_file.sv
      - source/pc_unit.sv
      - source/operand_adder.sv
      - source/mem_request.sv
      - source/load_result.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_memory.sv
      - verif/rv_core_tb.sv
